/* design/column_drain.sv */
// Column drain
// Visits the busy columns in ascending order, steps the arbiter of the
// active column and turns its grants into the output hit stream
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module column_drain
    import pix_readout_pkg::*;
(
    input  logic                      clk_i,          // System clock
    input  logic                      reset_i,        // Async reset, active high
    input  col_mask_t                 col_busy_i,     // Columns with hits left
    input  hit_frame_t                col_gnt_i,      // Grants of all arbiters
    input  row_addr_t [`PIX_COLS-1:0] col_xadd_i,     // Granted row per column
    input  col_mask_t                 col_release_i,  // Group release per column
    output col_mask_t                 col_en_o,       // Arbiter enables, one at most
    output logic                      clr_en_o,       // Clear the hit just accepted
    output col_addr_t                 clr_col_o,
    output row_addr_t                 clr_row_o,
    output logic                      hit_valid_o,    // Output stream valid
    output hit_addr_t                 hit_o,          // Output hit address
    input  logic                      hit_ready_i     // Output stream ready
);

    drain_state_t state_q;             // FSM state
    drain_state_t state_d;
    col_addr_t    act_col_q;           // Column being read
    col_addr_t    scan_col;            // Lowest busy column
    logic         scan_hit;            // Some column is busy
    logic         act_gnt;             // Active arbiter holds a grant
    logic         act_release;         // Active arbiter finished its group
    logic         out_free;            // Output slot empty or draining

    // Lowest busy column, scanned top down
    always_comb
    begin
        scan_col = '0;
        for (int c = `PIX_COLS - 1; c >= 0; c--)
        begin
            if (col_busy_i[c])
            begin
                scan_col = col_addr_t'(c);
            end
        end
    end

    assign scan_hit    = |col_busy_i;
    assign act_gnt     = |col_gnt_i[act_col_q];
    assign act_release = col_release_i[act_col_q];

    // Output stream comes straight from the registered grant
    assign hit_valid_o = (state_q == DRAIN_READ) && act_gnt;
    assign hit_o.col   = act_col_q;
    assign hit_o.row   = col_xadd_i[act_col_q];
    assign out_free    = !hit_valid_o || hit_ready_i;

    // Hold the arbiter still under back-pressure so the grant stays put
    always_comb
    begin
        col_en_o = '0;
        if ((state_q == DRAIN_READ) && out_free)
        begin
            col_en_o[act_col_q] = 1'b1;
        end
    end

    // Accepted hit gets cleared in the latch on the same edge
    assign clr_en_o  = hit_valid_o && hit_ready_i;
    assign clr_col_o = act_col_q;
    assign clr_row_o = hit_o.row;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            DRAIN_IDLE:
            begin
                if (scan_hit)
                begin
                    state_d = DRAIN_SCAN;        // New frame landed
                end
            end
            DRAIN_SCAN:
            begin
                state_d = scan_hit ? DRAIN_READ : DRAIN_IDLE;
            end
            DRAIN_READ:
            begin
                if (act_release)
                begin
                    state_d = DRAIN_SCAN;        // Column empty, look for the next
                end
            end
            default:
            begin
                state_d = DRAIN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q   <= DRAIN_IDLE;
            act_col_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            if ((state_q == DRAIN_SCAN) && scan_hit)
            begin
                act_col_q <= scan_col;           // Lock the column for READ
            end
        end
    end

endmodule

/* design/hit_frame_latch.sv */
// Hit frame latch
// Takes one frame of hit flags while the matrix is empty and keeps the
// hits still to be read, clearing each one as the drain hands it out
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module hit_frame_latch
    import pix_readout_pkg::*;
(
    input  logic       clk_i,          // System clock
    input  logic       reset_i,        // Async reset, active high
    input  logic       frame_valid_i,  // Frame offered
    input  hit_frame_t frame_i,        // Hit flags of the frame
    output logic       frame_ready_o,  // Matrix empty, frame can be taken
    input  logic       clr_en_i,       // Clear one hit this edge
    input  col_addr_t  clr_col_i,      // Column of the hit to clear
    input  row_addr_t  clr_row_i,      // Row of the hit to clear
    output hit_frame_t col_req_o,      // Remaining hits, to the arbiters
    output col_mask_t  col_busy_o      // Column still has hits
);

    hit_frame_t hit_q;                 // Hits not yet read out
    hit_frame_t clr_mask;              // One-hot of the hit being cleared
    logic       frame_acc;             // Frame handshake

    assign frame_acc = frame_valid_i && frame_ready_o;

    // Decode the clear request into a single bit of the matrix
    always_comb
    begin
        clr_mask = '0;
        if (clr_en_i)
        begin
            clr_mask[clr_col_i][clr_row_i] = 1'b1;
        end
    end

    // Load on accept, otherwise knock out the bit just read
    // Both never happen together since clears need a busy column
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            hit_q <= '0;                         // Nothing pending after reset
        end
        else if (frame_acc)
        begin
            hit_q <= frame_i;                    // New frame
        end
        else
        begin
            hit_q <= hit_q & ~clr_mask;          // Drop the accepted hit
        end
    end

    // Per column not-empty flags
    always_comb
    begin
        for (int c = 0; c < `PIX_COLS; c++)
        begin
            col_busy_o[c] = |hit_q[c];
        end
    end

    assign frame_ready_o = ~|col_busy_o;         // Only when the whole matrix is drained
    assign col_req_o     = hit_q;                // Stored masks drive the arbiter requests

endmodule

/* design/pix_readout_cfg.svh */
// Pixel readout configuration
// Matrix size and the widths of the encoded hit address
`ifndef PIX_READOUT_CFG_SVH
`define PIX_READOUT_CFG_SVH

// Matrix geometry
`define PIX_ROWS    8       // Rows per column
`define PIX_COLS    4       // Columns in the matrix

// Address widths
`define ROW_ADDR_W  3       // Enough for PIX_ROWS
`define COL_ADDR_W  2       // Enough for PIX_COLS

`endif

/* design/pix_readout_pkg.sv */
// Pixel readout types
// Masks, addresses, the input frame, the output hit word and the drain states
`include "pix_readout_cfg.svh"

package pix_readout_pkg;

    typedef logic [`PIX_ROWS-1:0]   row_mask_t;    // One bit per row of a column
    typedef logic [`ROW_ADDR_W-1:0] row_addr_t;    // Encoded row index
    typedef logic [`COL_ADDR_W-1:0] col_addr_t;    // Encoded column index
    typedef logic [`PIX_COLS-1:0]   col_mask_t;    // One bit per column

    // Whole matrix of hit flags, indexed by column
    typedef row_mask_t [`PIX_COLS-1:0] hit_frame_t;

    // Output word of the readout stream
    typedef struct packed {
        col_addr_t col;                             // Column of the hit
        row_addr_t row;                             // Row of the hit
    } hit_addr_t;

    // Column drain FSM
    typedef enum logic [1:0] {
        DRAIN_IDLE,                                 // Matrix empty
        DRAIN_SCAN,                                 // Picking the next busy column
        DRAIN_READ                                  // Reading out one column
    } drain_state_t;

endpackage

/* design/pix_readout_top.sv */
// Pixel matrix hit readout
// Frame latch, one row arbiter per column and the column drain
// turning a frame of hit flags into a stream of {column, row} addresses
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module pix_readout_top
    import pix_readout_pkg::*;
(
    input  logic       clk_i,          // System clock
    input  logic       reset_i,        // Async reset, active high
    input  logic       frame_valid_i,  // Frame input stream
    input  hit_frame_t frame_i,
    output logic       frame_ready_o,
    output logic       hit_valid_o,    // Hit output stream
    output hit_addr_t  hit_o,
    input  logic       hit_ready_i
);

    hit_frame_t                col_req;      // Stored hits per column
    hit_frame_t                col_gnt;      // Arbiter grants
    row_addr_t [`PIX_COLS-1:0] col_xadd;     // Arbiter row addresses
    col_mask_t                 col_busy;     // Column has hits left
    col_mask_t                 col_en;       // Arbiter enables
    col_mask_t                 col_release;  // Arbiter group releases
    logic                      clr_en;       // Hit clear to the latch
    col_addr_t                 clr_col;
    row_addr_t                 clr_row;

    hit_frame_latch u_hit_frame_latch (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .frame_valid_i (frame_valid_i),
        .frame_i       (frame_i),
        .frame_ready_o (frame_ready_o),
        .clr_en_i      (clr_en),
        .clr_col_i     (clr_col),
        .clr_row_i     (clr_row),
        .col_req_o     (col_req),
        .col_busy_o    (col_busy)
    );

    // One arbiter per column
    for (genvar c = 0; c < `PIX_COLS; c++)
    begin : g_col
        row_arbiter u_row_arbiter (
            .clk_i         (clk_i),
            .reset_i       (reset_i),
            .enable_i      (col_en[c]),
            .req_i         (col_req[c]),
            .gnt_o         (col_gnt[c]),
            .xadd_o        (col_xadd[c]),
            .grp_release_o (col_release[c])
        );
    end

    column_drain u_column_drain (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .col_busy_i    (col_busy),
        .col_gnt_i     (col_gnt),
        .col_xadd_i    (col_xadd),
        .col_release_i (col_release),
        .col_en_o      (col_en),
        .clr_en_o      (clr_en),
        .clr_col_o     (clr_col),
        .clr_row_o     (clr_row),
        .hit_valid_o   (hit_valid_o),
        .hit_o         (hit_o),
        .hit_ready_i   (hit_ready_i)
    );

endmodule

/* design/row_arbiter.sv */
// Row arbiter of one column
// Grants the requesting rows one at a time, lowest first, encodes the granted
// row and flags the end of the group once no request is left above the mask
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module row_arbiter
    import pix_readout_pkg::*;
(
    input  logic      clk_i,           // System clock
    input  logic      reset_i,         // Async reset, active high
    input  logic      enable_i,        // Advance the grant on this edge
    input  row_mask_t req_i,           // Rows with hits
    output row_mask_t gnt_o,           // Registered one-hot grant
    output row_addr_t xadd_o,          // Row index of the grant
    output logic      grp_release_o    // One-cycle pulse, column finished
);

    row_mask_t mask_q;                 // Rows still eligible, above the last grant
    row_mask_t mask_req;               // Requests that pass the mask
    row_mask_t pick;                   // Lowest surviving request, one-hot
    row_mask_t nxt_mask;               // Mask after the current pick
    logic      pick_none;              // Nothing left above the mask

    assign mask_req = req_i & mask_q;

    // Priority pick, scanned top down so the lowest row is written last
    always_comb
    begin
        pick = '0;
        for (int i = `PIX_ROWS - 1; i >= 0; i--)
        begin
            if (mask_req[i])
            begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign pick_none = (pick == '0);

    // Only rows above the pick stay eligible
    // With no pick the mask opens again for the next group
    always_comb
    begin
        nxt_mask = '1;
        for (int i = 0; i < `PIX_ROWS; i++)
        begin
            if (pick[i])
            begin
                nxt_mask = row_mask_t'({`PIX_ROWS{1'b1}} << (i + 1));
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q        <= '1;               // All rows eligible
            gnt_o         <= '0;               // No grant
            grp_release_o <= 1'b0;
        end
        else
        begin
            // Requests remain but all sit at or below the last grant
            grp_release_o <= enable_i && pick_none && (|req_i);
            if (enable_i)
            begin
                mask_q <= nxt_mask;
                gnt_o  <= pick;                // Zero once the group is done
            end
        end
    end

    // Encode the registered grant, one-hot so no priority needed
    always_comb
    begin
        xadd_o = '0;
        for (int i = 0; i < `PIX_ROWS; i++)
        begin
            if (gnt_o[i])
            begin
                xadd_o = row_addr_t'(i);
            end
        end
    end

endmodule

/* sources.f */
+incdir+design
design/pix_readout_pkg.sv
design/hit_frame_latch.sv
design/row_arbiter.sv
design/column_drain.sv
design/pix_readout_top.sv
test/pix_readout_checker.sv
test/pix_readout_tb.sv

/* test/pix_readout_checker.sv */
// Readout checker
// Grant, enable and handshake rules of the pixel readout, bound to the top level
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module pix_readout_checker
    import pix_readout_pkg::*;
(
    input logic       clk_i,           // System clock
    input logic       reset_i,         // Async reset, active high
    input hit_frame_t col_gnt_i,       // Arbiter grants
    input col_mask_t  col_en_i,        // Arbiter enables
    input logic       frame_ready_i,   // Frame port ready
    input logic       hit_valid_i,     // Hit stream valid
    input hit_addr_t  hit_i,           // Hit stream data
    input logic       hit_ready_i      // Hit stream ready
);

    int unsigned fail_cnt = 0;         // Failed assertions, read by the testbench

    // Each arbiter grants one row at most
    for (genvar c = 0; c < `PIX_COLS; c++)
    begin : g_gnt
        a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
            $onehot0(col_gnt_i[c]))
        else
        begin
            $error("column %0d grant has more than one row set", c);
            fail_cnt++;
        end
    end

    // Stalled hit keeps its address
    a_hit_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        hit_valid_i && !hit_ready_i |=> hit_valid_i && $stable(hit_i))
    else
    begin
        $error("hit output changed or dropped while stalled");
        fail_cnt++;
    end

    // A hit on the output is still stored, so the matrix is not empty
    a_frame_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        hit_valid_i |-> !frame_ready_i)
    else
    begin
        $error("frame port ready while hits are pending");
        fail_cnt++;
    end

    a_one_enable: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(col_en_i))
    else
    begin
        $error("more than one column enabled");
        fail_cnt++;
    end

endmodule

bind pix_readout_top pix_readout_checker u_pix_readout_checker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .col_gnt_i     (col_gnt),
    .col_en_i      (col_en),
    .frame_ready_i (frame_ready_o),
    .hit_valid_i   (hit_valid_o),
    .hit_i         (hit_o),
    .hit_ready_i   (hit_ready_i)
);

/* test/pix_readout_tb.sv */
// Pixel readout testbench
// Replays the frames of the trace file under its ready patterns and compares
// the hit stream with the expected addresses
`timescale 1ns/1ns
`include "pix_readout_cfg.svh"

module pix_readout_tb
    import pix_readout_pkg::*;
();

    localparam int RUN_LIMIT   = 600;  // Cycles allowed per test
    localparam int WATCH_CYC   = 8;    // Quiet cycles after the last hit
    localparam int RESET_CYC   = 8;

    logic       clk_i;
    logic       reset_i;
    logic       frame_valid_i;
    hit_frame_t frame_i;
    logic       frame_ready_o;
    logic       hit_valid_o;
    hit_addr_t  hit_o;
    logic       hit_ready_i;

    integer     seed;                  // $random state
    int         err_cnt;
    int         test_cnt;
    int         pass_cnt;
    int         fd;                    // Trace file handle
    string      tok;
    string      test_name;
    string      ready_pat;             // Bit string or rand
    hit_frame_t frame_a;               // First frame of the test
    hit_frame_t frame_b;               // Frame offered while A drains
    logic       has_b;
    int         n_exp;
    hit_addr_t  exp_hits[$];           // Expected hit sequence

    pix_readout_top u_pix_readout_top (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .frame_valid_i (frame_valid_i),
        .frame_i       (frame_i),
        .frame_ready_o (frame_ready_o),
        .hit_valid_o   (hit_valid_o),
        .hit_o         (hit_o),
        .hit_ready_i   (hit_ready_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;    // 40 ns period
    end

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (RESET_CYC) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
    endtask

    task automatic check_hit(string name, int idx, hit_addr_t exp, hit_addr_t act);
        if (exp !== act)
        begin
            $display("error %s hit %0d expected %h (c%0d r%0d) actual %h (c%0d r%0d)",
                     name, idx, exp, exp.col, exp.row, act, act.col, act.row);
            err_cnt++;
        end
    endtask

    task automatic check_count(string name, string what, int exp, int act);
        if (exp != act)
        begin
            $display("error %s %s expected %0d actual %0d", name, what, exp, act);
            err_cnt++;
        end
    endtask

    // Number of hits in a frame
    function automatic int count_bits(hit_frame_t f);
        int n;
        n = 0;
        for (int i = 0; i < $bits(f); i++)
        begin
            n += f[i / `PIX_ROWS][i % `PIX_ROWS];
        end
        return n;
    endfunction

    function automatic logic ready_bit(int cyc);
        logic b;
        if (ready_pat == "rand")
        begin
            b = ($random(seed) & 1) != 0;
        end
        else
        begin
            b = (ready_pat[cyc % ready_pat.len()] == "1");
        end
        return b;
    endfunction

    // Next token of the trace, skipping comment lines
    task automatic read_token(output string t);
        int    rc;
        string rest;
        t  = "";
        rc = $fscanf(fd, "%s", t);
        while (rc == 1 && t.len() > 0 && t[0] == "#")
        begin
            rc = $fgets(rest, fd);       // Drop the rest of the comment
            rc = $fscanf(fd, "%s", t);
        end
        if (rc != 1)
        begin
            t = "";
        end
    endtask

    task automatic run_test();
        int  got;                      // Hits taken from the DUT
        int  cyc;
        int  phase;                    // 0 offer A, 1 offer B, 2 frames done
        int  errs_before;
        int  a_bits;
        bit  acc;
        errs_before = err_cnt;
        got         = 0;
        cyc         = 0;
        phase       = 0;
        acc         = 1'b0;
        a_bits      = count_bits(frame_a);
        test_cnt++;
        while ((phase < 2 || got < n_exp) && cyc < RUN_LIMIT)
        begin
            @(posedge clk_i);
            #2;
            if (acc)
            begin
                phase = (phase == 0 && has_b) ? 1 : 2;
                acc   = 1'b0;
            end
            frame_valid_i = (phase < 2);
            frame_i       = (phase == 1) ? frame_b : frame_a;
            hit_ready_i   = ready_bit(cyc);
            @(negedge clk_i);                    // Inputs and outputs settled here
            if (frame_valid_i && frame_ready_o)
            begin
                acc = 1'b1;
                if (phase == 1)
                begin
                    check_count(test_name, "hits before second frame", a_bits, got);
                end
            end
            if (hit_valid_o && hit_ready_i)
            begin
                if (got < n_exp)
                begin
                    check_hit(test_name, got, exp_hits[got], hit_o);
                end
                got++;
            end
            cyc++;
        end
        if (cyc >= RUN_LIMIT)
        begin
            $display("%s timed out, %0d of %0d hits read", test_name, got, n_exp);
            err_cnt++;
            frame_valid_i = 1'b0;
            apply_reset();                       // Recover for the next test
        end
        else
        begin
            // Watch for extra hits, frame port must reopen
            for (int w = 0; w < WATCH_CYC; w++)
            begin
                @(posedge clk_i);
                #2;
                frame_valid_i = 1'b0;
                hit_ready_i   = 1'b1;
                @(negedge clk_i);
                if (hit_valid_o && hit_ready_i)
                begin
                    got++;
                end
            end
            if (!frame_ready_o)
            begin
                $display("%s frame_ready_o stayed low after the readout", test_name);
                err_cnt++;
            end
            check_count(test_name, "hit count", n_exp, got);
        end
        if (err_cnt == errs_before)
        begin
            pass_cnt++;
            $display("pass  %s  %0d hits", test_name, got);
        end
        else
        begin
            $display("fail  %s  %0d hits", test_name, got);
        end
    endtask

    initial
    begin
        logic [31:0] word;
        seed          = 8852;
        err_cnt       = 0;
        test_cnt      = 0;
        pass_cnt      = 0;
        reset_i       = 1'b1;
        frame_valid_i = 1'b0;
        frame_i       = '0;
        hit_ready_i   = 1'b0;
        apply_reset();
        fd = $fopen("test/pix_readout_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file test/pix_readout_trace.txt");
            err_cnt++;
        end
        else
        begin
            read_token(tok);
            while (tok == "T")
            begin
                read_token(test_name);
                read_token(tok);
                void'($sscanf(tok, "%h", word));
                frame_a = hit_frame_t'(word);
                read_token(tok);
                has_b = (tok != "-");
                void'($sscanf(tok, "%h", word));
                frame_b = has_b ? hit_frame_t'(word) : '0;
                read_token(ready_pat);
                read_token(tok);
                void'($sscanf(tok, "%d", n_exp));
                exp_hits.delete();
                for (int i = 0; i < n_exp; i++)
                begin
                    read_token(tok);
                    void'($sscanf(tok, "%h", word));
                    exp_hits.push_back(hit_addr_t'(word[$bits(hit_addr_t)-1:0]));
                end
                run_test();
                read_token(tok);
            end
            $fclose(fd);
        end
        if (test_cnt == 0)
        begin
            $display("no tests were found in the trace file");
            err_cnt++;
        end
        err_cnt += u_pix_readout_top.u_pix_readout_checker.fail_cnt;  // Bound assertions
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt,
                 u_pix_readout_top.u_pix_readout_checker.fail_cnt);
        if (err_cnt == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/pix_readout_trace.txt */
# T name frame(hex, column 3 in top byte) second_frame(hex or -) ready(bits or rand) hit_count
# Then the expected hits as hex {col,row} words, col in bits 4:3, row in bits 2:0
T single_hit 00200000 - 1 1
15
T one_column 0000C900 - 1 4
08 0B 0E 0F
T spread_columns 04810012 - 1 5
01 04 10 17 1A
T back_pressure 21000C80 - 1001101 5
07 0A 0B 18 1D
T random_ready 03A00055 - rand 8
00 02 04 06 15 17 18 19
T full_frame FFFFFFFF - 1 32
00 01 02 03 04 05 06 07
08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17
18 19 1A 1B 1C 1D 1E 1F
T full_frame_stalled FFFFFFFF - 0110 32
00 01 02 03 04 05 06 07
08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17
18 19 1A 1B 1C 1D 1E 1F
# Second frame waits until the first one is drained
T queued_frame 80000600 00100008 1 5
09 0A 1F
03 14
T queued_random 00030100 000000C0 rand 5
08 10 11
06 07
